//--- hdl/ss_best_track.sv
// strict-less replace, so among equal neighbours the earliest index wins; no reload of best on start
`include "ss_cfg.svh"

module ss_best_track import ss_pkg::*; (
    input  logic        CLK,
    input  logic        RST_N,
    input  ana_t        ana_bits,
    meas_if.track       meas
);

    ana_t     best_q;
    nbr_idx_t best_nbr_q;
    logic     found_q;
    logic     better;

    // neighbour beats the committed point
    assign better = (ana_bits < best_q);

    ////////////////////////////////////////////////////////////
    // best value and winner record
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            best_q     <= {`SS_ANA_W{1'b1}};
            best_nbr_q <= '0;
            found_q    <= 1'b0;
        end else if (meas.meas_take) begin
            if (meas.meas_base) begin
                // baseline always taken as is
                best_q <= ana_bits;
            end else if (better) begin
                best_q     <= ana_bits;
                best_nbr_q <= meas.nbr;
                found_q    <= 1'b1;
            end
        end else if (meas.sweep_clr) begin
            // new sweep around the committed point
            found_q <= 1'b0;
        end
    end

    // results back to the sequencer
    assign meas.best_ana = best_q;
    assign meas.best_nbr = best_nbr_q;
    assign meas.found    = found_q;

endmodule

//--- hdl/ss_cfg.svh
// fixed-point widths only; SS_LANES must stay a power of two so the lane index wraps cleanly
`ifndef SS_CFG_SVH
`define SS_CFG_SVH

// bits per trim code, codes wrap modulo 2**SS_CODE_W
`define SS_CODE_W 5

// number of trim lanes on the analog block
`define SS_LANES 4

// measurement width, lower value is better
`define SS_ANA_W 8

// move counter and move limit width
`define SS_ITER_W 11

`endif

//--- hdl/ss_ifc.sv
// internal links only; one probe in flight, the sequencer holds nbr stable across each measurement

////////////////////////////////////////////////////////////
// lane control, sequencer to every trim lane
////////////////////////////////////////////////////////////
interface lane_ctrl_if import ss_pkg::*; ();

    // load slice of init_tune into committed code
    logic     load_init;
    // neighbour applied, level through apply and wait
    logic     probe_on;
    // current neighbour index
    nbr_idx_t nbr;
    // one-cycle move of the addressed lane
    logic     commit;

    modport master (
        output load_init,
        output probe_on,
        output nbr,
        output commit
    );

    modport lane (
        input load_init,
        input probe_on,
        input nbr,
        input commit
    );

endinterface

////////////////////////////////////////////////////////////
// measurement path, sequencer and best tracker
////////////////////////////////////////////////////////////
// nbr comes in from the lane control bundle
interface meas_if import ss_pkg::*; (input nbr_idx_t nbr);

    logic     meas_take;
    logic     meas_base;
    logic     sweep_clr;
    // results, valid the cycle after meas_take
    logic     found;
    nbr_idx_t best_nbr;
    ana_t     best_ana;

    modport seq (
        output meas_take,
        output meas_base,
        output sweep_clr,
        input  found,
        input  best_nbr,
        input  best_ana
    );

    modport track (
        input  nbr,
        input  meas_take,
        input  meas_base,
        input  sweep_clr,
        output found,
        output best_nbr,
        output best_ana
    );

endinterface

//--- hdl/ss_pkg.sv
// shared types for the neighbour search; widths come from ss_cfg.svh and are not parameters
`include "ss_cfg.svh"

package ss_pkg;

    // one trim code, unsigned, arithmetic wraps
    typedef logic [`SS_CODE_W-1:0] code_t;

    // lane number
    typedef logic [$clog2(`SS_LANES)-1:0] lane_idx_t;

    // neighbour index
    // bit 0 is the direction, 1 means +1
    // upper bits select the lane
    typedef logic [$clog2(`SS_LANES):0] nbr_idx_t;

    // measurement sample
    typedef logic [`SS_ANA_W-1:0] ana_t;

    // move count and limit
    typedef logic [`SS_ITER_W-1:0] iter_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        APPLY,
        WAIT_MEAS,
        DECIDE,
        MOVE,
        DONE
    } seq_state_e;

endpackage

//--- hdl/ss_probe_seq.sv
// mode_4d is sampled at start; nxt is ignored outside WAIT_MEAS and start is ignored while busy
`include "ss_cfg.svh"

module ss_probe_seq import ss_pkg::*; (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              start,
    input  logic              mode_4d,
    input  logic              nxt,
    input  iter_t             max_iter,
    input  ana_t              threshold,
    output logic              tune_valid,
    output logic              busy,
    output logic              done,
    output iter_t             iter_cnt,
    lane_ctrl_if.master       lane,
    meas_if.seq               meas
);

    seq_state_e state;
    seq_state_e state_nxt;

    // latched search mode, 1 = all four lanes
    logic     mode_q;
    // set while the baseline point is measured
    logic     base_q;
    logic     tune_valid_q;
    nbr_idx_t nbr_q;
    iter_t    iter_q;

    logic     start_ok;
    logic     last_nbr;
    logic     thr_hit;
    logic     sweep_go;
    iter_t    iter_inc;
    nbr_idx_t nbr_last;

    ////////////////////////////////////////////////////////////
    // decode helpers
    ////////////////////////////////////////////////////////////
    // restart only from idle or done
    assign start_ok = start && (state == IDLE || state == DONE);

    // 2-D sweep stops after lane 1 (+1), index 3
    assign nbr_last = mode_q ? nbr_idx_t'(2 * `SS_LANES - 1) : nbr_idx_t'(3);
    assign last_nbr = (nbr_q == nbr_last);

    // threshold accept on the committed point
    assign thr_hit  = (meas.best_ana <= threshold);
    assign iter_inc = iter_q + iter_t'(1);

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        sweep_go  = 1'b0;
        case (state)
            IDLE, DONE: begin
                if (start_ok) begin
                    state_nxt = APPLY;
                end
            end
            // codes settle this cycle, strobe follows
            APPLY: begin
                state_nxt = WAIT_MEAS;
            end
            WAIT_MEAS: begin
                if (nxt) begin
                    state_nxt = DECIDE;
                end
            end
            DECIDE: begin
                if (base_q) begin
                    // baseline done, maybe already good enough
                    if (thr_hit || iter_q == max_iter) begin
                        state_nxt = DONE;
                    end else begin
                        sweep_go  = 1'b1;
                        state_nxt = APPLY;
                    end
                end else if (!last_nbr) begin
                    state_nxt = APPLY;
                end else if (meas.found) begin
                    state_nxt = MOVE;
                end else begin
                    // no neighbour improved, local minimum
                    state_nxt = DONE;
                end
            end
            MOVE: begin
                // best_ana already holds the new point's value
                if (thr_hit || iter_inc == max_iter) begin
                    state_nxt = DONE;
                end else begin
                    sweep_go  = 1'b1;
                    state_nxt = APPLY;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state, neighbour and move registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state        <= IDLE;
            mode_q       <= 1'b0;
            base_q       <= 1'b0;
            tune_valid_q <= 1'b0;
            nbr_q        <= '0;
            iter_q       <= '0;
        end else begin
            state        <= state_nxt;
            // pulse one cycle after codes settle
            tune_valid_q <= (state == APPLY);
            if (start_ok) begin
                mode_q <= mode_4d;
                base_q <= 1'b1;
                nbr_q  <= '0;
                iter_q <= '0;
            end else if (sweep_go) begin
                base_q <= 1'b0;
                nbr_q  <= '0;
            end else if (state == DECIDE && !base_q) begin
                // at sweep end point nbr at the winner for commit
                nbr_q <= last_nbr ? meas.best_nbr : nbr_q + nbr_idx_t'(1);
            end
            if (state == MOVE) begin
                iter_q <= iter_inc;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////
    assign lane.load_init = start_ok;
    assign lane.probe_on  = !base_q && (state == APPLY || state == WAIT_MEAS);
    assign lane.nbr       = nbr_q;
    assign lane.commit    = (state == MOVE);

    assign meas.meas_take = (state == WAIT_MEAS) && nxt;
    assign meas.meas_base = base_q;
    assign meas.sweep_clr = sweep_go;

    assign tune_valid = tune_valid_q;
    assign busy       = (state != IDLE) && (state != DONE);
    assign done       = (state == DONE);
    assign iter_cnt   = iter_q;

endmodule

//--- hdl/ss_top.sv
// one point in flight; ana_bits is sampled only on the cycle nxt is high while waiting for it
`include "ss_cfg.svh"

module ss_top import ss_pkg::*; (
    input  logic                             CLK,
    input  logic                             RST_N,
    input  logic                             start,
    input  logic                             mode_4d,
    input  logic [`SS_LANES*`SS_CODE_W-1:0]  init_tune,
    input  iter_t                            max_iter,
    input  ana_t                             threshold,
    input  logic                             nxt,
    input  ana_t                             ana_bits,
    output logic [`SS_LANES*`SS_CODE_W-1:0]  tune_bits,
    output logic                             tune_valid,
    output logic                             busy,
    output logic                             done,
    output ana_t                             best_ana,
    output iter_t                            iter_cnt
);

    lane_ctrl_if lane_i ();
    // tracker sees the probed neighbour through this bundle
    meas_if      meas_i (.nbr(lane_i.nbr));

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    ss_probe_seq seq_i (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .start      (start),
        .mode_4d    (mode_4d),
        .nxt        (nxt),
        .max_iter   (max_iter),
        .threshold  (threshold),
        .tune_valid (tune_valid),
        .busy       (busy),
        .done       (done),
        .iter_cnt   (iter_cnt),
        .lane       (lane_i.master),
        .meas       (meas_i.seq)
    );

    ////////////////////////////////////////////////////////////
    // trim lanes, lane 0 in the low bits
    ////////////////////////////////////////////////////////////
    for (genvar g = 0; g < `SS_LANES; g++) begin : g_lane
        ss_tune_lane #(.LANE_ID(g)) lane_u (
            .CLK       (CLK),
            .RST_N     (RST_N),
            .init_code (init_tune[g*`SS_CODE_W +: `SS_CODE_W]),
            .ctrl      (lane_i.lane),
            .code      (tune_bits[g*`SS_CODE_W +: `SS_CODE_W])
        );
    end

    // measurement compare
    ss_best_track track_i (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .ana_bits (ana_bits),
        .meas     (meas_i.track)
    );

    assign best_ana = meas_i.best_ana;

endmodule

//--- hdl/ss_tune_lane.sv
// codes wrap modulo 32, so 0 - 1 gives 31; the applied code is combinational from the registers
`include "ss_cfg.svh"

module ss_tune_lane import ss_pkg::*; #(
    parameter int LANE_ID = 0
) (
    input  logic        CLK,
    input  logic        RST_N,
    input  code_t       init_code,
    lane_ctrl_if.lane   ctrl,
    output code_t       code
);

    code_t     committed;
    code_t     step_code;
    lane_idx_t nbr_lane;
    logic      hit;

    // lane field of the neighbour index
    assign nbr_lane = ctrl.nbr[$bits(nbr_idx_t)-1:1];
    assign hit      = (nbr_lane == lane_idx_t'(LANE_ID));

    // even index steps down, odd steps up
    assign step_code = ctrl.nbr[0] ? committed + `SS_CODE_W'(1)
                                   : committed - `SS_CODE_W'(1);

    ////////////////////////////////////////////////////////////
    // committed code
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            committed <= '0;
        end else if (ctrl.load_init) begin
            committed <= init_code;
        end else if (ctrl.commit && hit) begin
            // accepted move, same step as the probe
            committed <= step_code;
        end
    end

    // neighbour only while this lane is probed
    assign code = (ctrl.probe_on && hit) ? step_code : committed;

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the neighbour search testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f src.f --top-module tb_ss_top -o tb_ss_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_ss_top > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$SIM_LOG"
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"
if grep -q "Errors found" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- src.f
+incdir+hdl
+incdir+verif
hdl/ss_pkg.sv
hdl/ss_ifc.sv
hdl/ss_probe_seq.sv
hdl/ss_tune_lane.sv
hdl/ss_best_track.sv
hdl/ss_top.sv
verif/tb_ss_top.sv

//--- verif/tb_ss_tests.svh
// included inside tb_ss_top; tasks drive the DUT ports and read module-level counters
`ifndef TB_SS_TESTS_SVH
`define TB_SS_TESTS_SVH

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////
task automatic check_val(input string test, input string what,
                         input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
        err_cnt++;
        $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test, what, exp_v, act_v);
    end
endtask

// one result line per test
task automatic end_test(input string test, input int err0);
    tests_run++;
    if (err_cnt == err0) begin
        $display("test %s: ok", test);
    end else begin
        tests_failed++;
        $display("test %s: %0d check(s) failed", test, err_cnt - err0);
    end
endtask

function automatic point_t rand_point();
    return point_t'($random(seed));
endfunction

// neighbour n, even steps down, odd steps up on lane n/2
function automatic point_t step_point(input point_t p, input int n);
    logic [`SS_CODE_W-1:0] c;
    c = p[(n / 2)*CW +: CW];
    c = (n % 2 == 1) ? c + `SS_CODE_W'(1) : c - `SS_CODE_W'(1);
    p[(n / 2)*CW +: CW] = c;
    return p;
endfunction

// reference search: strict-less, lowest index wins, stop on threshold, limit or no gain
task automatic golden_search(input point_t init, input point_t tgt, input bit m4d,
                             input int max_it, input int thr, output point_t pt,
                             output int best, output int moves, output int pulses);
    int  last;
    int  c;
    int  b_n;
    int  b_v;
    bit  go;
    pt     = init;
    best   = point_cost(init, tgt);
    moves  = 0;
    pulses = 1;
    last   = m4d ? 2 * LANES - 1 : 3;
    go     = 1'b1;
    while (go) begin
        if (best <= thr || moves == max_it) begin
            go = 1'b0;
        end else begin
            b_v = best;
            b_n = -1;
            for (int n = 0; n <= last; n++) begin
                c = point_cost(step_point(pt, n), tgt);
                pulses++;
                if (c < b_v) begin
                    b_v = c;
                    b_n = n;
                end
            end
            if (b_n < 0) begin
                go = 1'b0;
            end else begin
                pt    = step_point(pt, b_n);
                best  = b_v;
                moves++;
            end
        end
    end
endtask

// set up, pulse start, then wait for done
task automatic run_search(input string test, input point_t init, input point_t tgt,
                          input bit m4d, input int max_it, input int thr, output bit ok);
    int n;
    @(posedge CLK);
    #2;
    init_tune = init;
    target    = tgt;
    mode_4d   = m4d;
    max_iter  = iter_t'(max_it);
    threshold = ana_t'(thr);
    valid_cnt = 0;
    start     = 1'b1;
    @(posedge CLK);
    #2;
    start = 1'b0;
    // initial point applied one cycle after start
    check_val(test, "tune_bits after start", 32'(init), 32'(tune_bits));
    check_val(test, "busy after start", 32'(1), 32'(busy));
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
        @(negedge CLK);
        ok = (done === 1'b1);
        n++;
    end
    if (!ok) begin
        err_cnt++;
        $display("test %s: done did not rise within %0d cycles", test, TIMEOUT);
    end
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////
task automatic test_reset_values();
    int err0;
    err0 = err_cnt;
    @(negedge CLK);
    check_val("reset_values", "done", 32'(0), 32'(done));
    check_val("reset_values", "busy", 32'(0), 32'(busy));
    check_val("reset_values", "tune_valid", 32'(0), 32'(tune_valid));
    check_val("reset_values", "tune_bits", 32'(0), 32'(tune_bits));
    check_val("reset_values", "iter_cnt", 32'(0), 32'(iter_cnt));
    check_val("reset_values", "best_ana", 32'hff, 32'(best_ana));
    end_test("reset_values", err0);
endtask

// threshold above any cost, baseline alone finishes
task automatic test_threshold_stop();
    point_t init;
    point_t tgt;
    bit     ok;
    int     err0;
    err0 = err_cnt;
    init = rand_point();
    tgt  = rand_point();
    run_search("threshold_stop", init, tgt, 1'b1, 2047, 255, ok);
    if (ok) begin
        check_val("threshold_stop", "tune_valid count", 32'(1), 32'(valid_cnt));
        check_val("threshold_stop", "iter_cnt", 32'(0), 32'(iter_cnt));
        check_val("threshold_stop", "tune_bits", 32'(init), 32'(tune_bits));
        check_val("threshold_stop", "best_ana", 32'(point_cost(init, tgt)), 32'(best_ana));
    end
    end_test("threshold_stop", err0);
endtask

// each move lowers the cost by exactly one
task automatic test_full_converge();
    point_t init;
    point_t tgt;
    bit     ok;
    int     err0;
    err0 = err_cnt;
    init = rand_point();
    tgt  = rand_point();
    run_search("full_converge", init, tgt, 1'b1, 2047, 0, ok);
    if (ok) begin
        check_val("full_converge", "tune_bits", 32'(tgt), 32'(tune_bits));
        check_val("full_converge", "best_ana", 32'(0), 32'(best_ana));
        check_val("full_converge", "iter_cnt", 32'(point_cost(init, tgt)), 32'(iter_cnt));
    end
    end_test("full_converge", err0);
endtask

task automatic test_iter_limit();
    point_t init;
    point_t tgt;
    point_t g_pt;
    int     g_best;
    int     g_moves;
    int     g_pulses;
    int     limit;
    bit     ok;
    int     err0;
    err0 = err_cnt;
    init = rand_point();
    tgt  = rand_point();
    // lane 0 far off so the limit is at least four moves
    tgt[CW-1:0] = init[CW-1:0] + `SS_CODE_W'(9);
    limit = point_cost(init, tgt) / 2;
    golden_search(init, tgt, 1'b1, limit, 0, g_pt, g_best, g_moves, g_pulses);
    run_search("iter_limit", init, tgt, 1'b1, limit, 0, ok);
    if (ok) begin
        check_val("iter_limit", "iter_cnt", 32'(limit), 32'(iter_cnt));
        check_val("iter_limit", "tune_bits", 32'(g_pt), 32'(tune_bits));
        check_val("iter_limit", "best_ana", 32'(g_best), 32'(best_ana));
        check_val("iter_limit", "tune_valid count", 32'(g_pulses), 32'(valid_cnt));
    end
    end_test("iter_limit", err0);
endtask

// lanes 2-3 stuck off target, cost floor above zero, ends on a failed sweep
task automatic test_two_lane();
    point_t init;
    point_t tgt;
    point_t g_pt;
    int     g_best;
    int     g_moves;
    int     g_pulses;
    bit     ok;
    int     err0;
    err0 = err_cnt;
    init = rand_point();
    tgt  = rand_point();
    tgt[3*CW-1:2*CW] = init[3*CW-1:2*CW] + `SS_CODE_W'(7);
    tgt[4*CW-1:3*CW] = init[4*CW-1:3*CW] + `SS_CODE_W'(9);
    golden_search(init, tgt, 1'b0, 2047, 0, g_pt, g_best, g_moves, g_pulses);
    run_search("two_lane", init, tgt, 1'b0, 2047, 0, ok);
    if (ok) begin
        check_val("two_lane", "lanes 2-3", 32'(init[4*CW-1:2*CW]), 32'(tune_bits[4*CW-1:2*CW]));
        // baseline, one sweep per move, then the sweep that finds nothing
        check_val("two_lane", "tune_valid count", 32'(1 + 4 * (g_moves + 1)),
                  32'(valid_cnt));
        check_val("two_lane", "iter_cnt", 32'(g_moves), 32'(iter_cnt));
        check_val("two_lane", "tune_bits", 32'(g_pt), 32'(tune_bits));
        check_val("two_lane", "best_ana", 32'(g_best), 32'(best_ana));
    end
    end_test("two_lane", err0);
endtask

// 0 minus one reaches 31 in a single move
task automatic test_code_wrap();
    point_t init;
    point_t tgt;
    bit     ok;
    int     err0;
    err0 = err_cnt;
    init          = rand_point();
    init[CW-1:0]  = '0;
    tgt           = init;
    tgt[CW-1:0]   = `SS_CODE_W'(CODES - 1);
    run_search("code_wrap", init, tgt, 1'b1, 2047, 0, ok);
    if (ok) begin
        check_val("code_wrap", "iter_cnt", 32'(1), 32'(iter_cnt));
        check_val("code_wrap", "tune_bits", 32'(tgt), 32'(tune_bits));
        check_val("code_wrap", "best_ana", 32'(0), 32'(best_ana));
        // baseline plus one full sweep
        check_val("code_wrap", "tune_valid count", 32'(1 + 2 * LANES), 32'(valid_cnt));
    end
    end_test("code_wrap", err0);
endtask

`endif

//--- verif/tb_ss_top.sv
// cost model always sums all four lanes; responder answers each tune_valid after 1 to 4 cycles
`include "ss_cfg.svh"

module tb_ss_top import ss_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LANES   = `SS_LANES;
    localparam int CW      = `SS_CODE_W;
    localparam int CODES   = 1 << `SS_CODE_W;
    // cycles allowed for one whole search
    localparam int TIMEOUT = 20000;

    typedef logic [`SS_LANES*`SS_CODE_W-1:0] point_t;

    logic   CLK = 1'b0;
    logic   RST_N;
    logic   start;
    logic   mode_4d;
    point_t init_tune;
    iter_t  max_iter;
    ana_t   threshold;
    logic   nxt;
    ana_t   ana_bits;
    point_t tune_bits;
    logic   tune_valid;
    logic   busy;
    logic   done;
    ana_t   best_ana;
    iter_t  iter_cnt;

    integer seed;
    // optimum of the analog model
    point_t target;
    int     valid_cnt;
    int     err_cnt;
    int     tests_run;
    int     tests_failed;

    always #10 CLK = ~CLK;

    ss_top dut_i (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .start      (start),
        .mode_4d    (mode_4d),
        .init_tune  (init_tune),
        .max_iter   (max_iter),
        .threshold  (threshold),
        .nxt        (nxt),
        .ana_bits   (ana_bits),
        .tune_bits  (tune_bits),
        .tune_valid (tune_valid),
        .busy       (busy),
        .done       (done),
        .best_ana   (best_ana),
        .iter_cnt   (iter_cnt)
    );

    ////////////////////////////////////////////////////////////
    // analog cost model
    ////////////////////////////////////////////////////////////
    // circular distance between two codes
    function automatic int code_dist(input logic [`SS_CODE_W-1:0] a, input logic [`SS_CODE_W-1:0] b);
        int d;
        d = int'(a) - int'(b);
        if (d < 0) begin
            d = -d;
        end
        if (d > CODES / 2) begin
            d = CODES - d;
        end
        return d;
    endfunction

    function automatic int point_cost(input point_t p, input point_t t);
        int sum;
        sum = 0;
        for (int l = 0; l < LANES; l++) begin
            sum += code_dist(p[l*CW +: CW], t[l*CW +: CW]);
        end
        return sum;
    endfunction

    // measurement responder, one point in flight
    always begin : responder
        int cost;
        int hold;
        @(negedge CLK);
        if (tune_valid === 1'b1) begin
            valid_cnt++;
            cost = point_cost(tune_bits, target);
            hold = $random(seed) & 3;
            repeat (hold) @(posedge CLK);
            @(posedge CLK);
            #2;
            nxt      = 1'b1;
            ana_bits = ana_t'(cost);
            @(posedge CLK);
            #2;
            nxt      = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // test list
    ////////////////////////////////////////////////////////////
    initial begin
        seed         = 32'h7af5_1610;
        RST_N        = 1'b0;
        start        = 1'b0;
        mode_4d      = 1'b1;
        init_tune    = '0;
        max_iter     = '0;
        threshold    = '0;
        nxt          = 1'b0;
        ana_bits     = '0;
        target       = '0;
        valid_cnt    = 0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(posedge CLK);
        #2;
        RST_N = 1'b1;

        test_reset_values();
        test_threshold_stop();
        test_full_converge();
        test_iter_limit();
        test_two_lane();
        test_code_wrap();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    `include "tb_ss_tests.svh"

endmodule
